// File: project.f
+incdir+source
source/axi_lite_pkg.sv
source/hbus_pkg.sv
source/hbus_req_reg.sv
source/hbus_axi_slave.sv
source/hbus_ca_shifter.sv
source/hbus_ctrl.sv
source/hbus_top.sv
bench/hram_model.sv
bench/hbus_props.sv
bench/hbus_tb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f project.f --top-module hbus_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f project.f \
		--top-module hbus_tb -Mdir $(OBJ_DIR) -o hbus_sim
	-./$(OBJ_DIR)/hbus_sim > sim.log 2>&1
	@cat sim.log
	@grep -q "Test OK" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// File: bench/hbus_tb.sv
`timescale 1ns/10ps

module hbus_tb
    import axi_lite_pkg::*;
    import hbus_pkg::*;
();

    typedef struct packed {
        logic        op_read;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;
        axil_resp_e  exp_resp;
        logic [7:0]  hold;
    } vec_t;

    logic      clk;
    logic      rst;
    axil_req_t axi_req;
    axil_rsp_t axi_rsp;
    hbus_out_t hbus_out;
    hbus_in_t  hbus_in;

    vec_t      vecs[$];
    logic      table_ready = 1'b0;
    int        errors = 0;
    int        checks = 0;
    integer    seed = 32'h3ae4_6409;

    hbus_top UUT (
        .clk       (clk),
        .rst       (rst),
        .axi_req_i (axi_req),
        .axi_rsp_o (axi_rsp),
        .hbus_o    (hbus_out),
        .hbus_i    (hbus_in)
    );

    hram_model u_mem (
        .clk    (clk),
        .pins_i (hbus_out),
        .pins_o (hbus_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_vec(input logic op_read, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wstrb,
                           input logic [31:0] exp_rdata, input axil_resp_e exp_resp,
                           input int hold);
        vec_t v;
        v.op_read   = op_read;
        v.addr      = addr;
        v.wdata     = wdata;
        v.wstrb     = wstrb;
        v.exp_rdata = exp_rdata;
        v.exp_resp  = exp_resp;
        v.hold      = 8'(hold);
        vecs.push_back(v);
    endtask

    task automatic build_table();
        logic [31:0] rnd [6];
        for (int k = 0; k < 6; k++) begin
            rnd[k] = $random(seed);
        end
        add_vec(0, 32'h0000_0000, rnd[0], 4'hf, '0, OKAY, 0);
        add_vec(1, 32'h0000_0000, '0, '0, rnd[0], OKAY, 0);
        // Halfword address bit 2 set, memory picks 2x latency
        add_vec(0, 32'h0000_0008, rnd[1], 4'hf, '0, OKAY, 0);
        add_vec(1, 32'h0000_0008, '0, '0, rnd[1], OKAY, 0);
        add_vec(0, 32'h0000_0004, rnd[2], 4'hf, '0, OKAY, 0);
        add_vec(1, 32'h0000_0004, '0, '0, rnd[2], OKAY, 0);
        add_vec(1, 32'h0000_0008, '0, '0, rnd[1], OKAY, 0);
        add_vec(0, 32'h0000_0000, rnd[3], 4'b0101, '0, OKAY, 0);
        add_vec(1, 32'h0000_0000, '0, '0, merge_bytes(rnd[0], rnd[3], 4'b0101), OKAY, 6);
        add_vec(1, 32'h0000_0004, '0, '0, rnd[2], OKAY, 0);
        add_vec(0, 32'h0000_0018, rnd[4], 4'hf, '0, OKAY, 5);
        add_vec(1, 32'h0000_0018, '0, '0, rnd[4], OKAY, 0);
        add_vec(0, 32'h0000_0018, rnd[5], 4'b1000, '0, OKAY, 0);
        add_vec(1, 32'h0000_0018, '0, '0, merge_bytes(rnd[4], rnd[5], 4'b1000), OKAY, 0);
        // Register space is never answered, error is sticky afterwards
        add_vec(1, 32'h8000_0000, '0, '0, '0, SLVERR, 0);
        add_vec(0, 32'h0000_0000, rnd[0], 4'hf, '0, SLVERR, 0);
        add_vec(1, 32'h0000_0000, '0, '0, '0, SLVERR, 0);
        add_vec(1, 32'h0000_0004, '0, '0, '0, SLVERR, 0);
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e got,
                              input axil_resp_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    // Keeps B or R waiting, may offer the next AR meanwhile
    task automatic hold_response(input int cycles, input logic next_read,
                                 input logic [31:0] next_addr);
        axil_rsp_t held;
        held = axi_rsp;
        if (next_read) begin
            axi_req.arvalid = 1'b1;
            axi_req.araddr  = next_addr;
        end
        repeat (cycles) begin
            @(negedge clk);
            checks++;
            if (axi_rsp !== held) begin
                errors++;
                $display("%0t response changed while ready was held low", $time);
            end
            if (axi_rsp.arready || axi_rsp.awready || axi_rsp.wready) begin
                errors++;
                $display("%0t new request accepted while a response was pending", $time);
            end
        end
    endtask

    task automatic axi_write(input vec_t v, input logic next_read,
                             input logic [31:0] next_addr, output axil_resp_e resp);
        logic aw_go;
        logic w_go;
        @(negedge clk);
        axi_req.awvalid = 1'b1;
        axi_req.awaddr  = v.addr;
        axi_req.wvalid  = 1'b1;
        axi_req.wdata   = v.wdata;
        axi_req.wstrb   = v.wstrb;
        while (axi_req.awvalid || axi_req.wvalid) begin
            aw_go = axi_req.awvalid && axi_rsp.awready;
            w_go  = axi_req.wvalid && axi_rsp.wready;
            @(negedge clk);
            if (aw_go) axi_req.awvalid = 1'b0;
            if (w_go) axi_req.wvalid = 1'b0;
        end
        while (!axi_rsp.bvalid) @(negedge clk);
        if (v.hold > 0) hold_response(int'(v.hold), next_read, next_addr);
        resp = axi_rsp.bresp;
        axi_req.bready = 1'b1;
        @(negedge clk);
        axi_req.bready = 1'b0;
    endtask

    task automatic axi_read(input vec_t v, input logic next_read,
                            input logic [31:0] next_addr, output logic [31:0] data,
                            output axil_resp_e resp);
        logic ar_go;
        @(negedge clk);
        axi_req.arvalid = 1'b1;
        axi_req.araddr  = v.addr;
        while (axi_req.arvalid) begin
            ar_go = axi_rsp.arready;
            @(negedge clk);
            if (ar_go) axi_req.arvalid = 1'b0;
        end
        while (!axi_rsp.rvalid) @(negedge clk);
        if (v.hold > 0) hold_response(int'(v.hold), next_read, next_addr);
        data = axi_rsp.rdata;
        resp = axi_rsp.rresp;
        axi_req.rready = 1'b1;
        @(negedge clk);
        axi_req.rready = 1'b0;
    endtask

    initial begin
        wait (table_ready);
        repeat (vecs.size() * 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles, transactions did not finish",
                 vecs.size() * 200);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        vec_t        v;
        logic        next_read;
        logic [31:0] next_addr;
        logic [31:0] rdata;
        axil_resp_e  resp;
        int          errs_before;
        axi_req = '0;
        rst     = 1'b1;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < vecs.size(); i++) begin
            v           = vecs[i];
            errs_before = errors;
            next_read   = (i + 1 < vecs.size()) && vecs[i+1].op_read;
            next_addr   = (i + 1 < vecs.size()) ? vecs[i+1].addr : '0;
            if (v.op_read) begin
                axi_read(v, next_read, next_addr, rdata, resp);
                check_resp("rresp", resp, v.exp_resp);
                if (v.exp_resp == OKAY) check_data("rdata", rdata, v.exp_rdata);
            end else begin
                axi_write(v, next_read, next_addr, resp);
                check_resp("bresp", resp, v.exp_resp);
            end
            $display("%0t vec %0d %s addr %h resp %s: %s", $time, i,
                     v.op_read ? "read " : "write", v.addr, resp.name(),
                     errors == errs_before ? "pass" : "mismatch");
        end
        $display("%0d vectors, %0d checks, %0d errors", vecs.size(), checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: bench/hbus_props.sv
`timescale 1ns/10ps

module hbus_props
    import hbus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input hbus_state_e state_i,
    input hbus_out_t   pins_i
);

    // Bus stays deselected while the memory is in reset
    rstn_bus_idle: assert property (@(posedge clk)
        !pins_i.rstn |-> pins_i.csn && !pins_i.ck_en)
        else $error("csn low or ck_en high while the memory reset is active");

    // Memory owns dq during the read data phase
    read_no_drive: assert property (@(posedge clk) disable iff (rst)
        state_i == ST_READ |-> !pins_i.dq_oe)
        else $error("dq driven by the controller during a read data phase");

    error_no_select: assert property (@(posedge clk) disable iff (rst)
        state_i == ST_ERROR |-> pins_i.csn)
        else $error("csn low while the controller is in its error state");

endmodule

bind hbus_ctrl hbus_props u_props (
    .clk     (clk),
    .rst     (rst),
    .state_i (state_q),
    .pins_i  (hbus_o)
);

// File: bench/hram_model.sv
`timescale 1ns/10ps
`include "hbus_macros.svh"

module hram_model
    import hbus_pkg::*;
(
    input  logic      clk,
    input  hbus_out_t pins_i,
    output hbus_in_t  pins_o
);

    localparam int DEPTH      = 256;
    localparam int LAT1_START = 3 + `TACC_COUNT;
    localparam int LAT2_START = 3 + 2 * `TACC_COUNT;

    logic [15:0] mem [DEPTH];
    hbus_ca_t    ca_q;
    logic [30:0] addr;
    logic [7:0]  idx;
    int          cyc_q;
    int          widx_q;
    int          data_start;
    logic        lat2_q;
    logic        rd_active_q;
    logic [15:0] rd_dq_q;
    logic        rstn;

    assign rstn       = pins_i.rstn;
    assign addr       = {ca_q.addr_hi[27:0], ca_q.addr_lo};
    assign idx        = addr[7:0] + widx_q[7:0];
    assign data_start = lat2_q ? LAT2_START : LAT1_START;

    always_comb begin
        pins_o.dq   = rd_active_q ? rd_dq_q : 16'h0000;
        pins_o.rwds = rd_active_q ? 2'b11 : 2'b00;
        // Bit 2 of the last CA word asks for double latency
        if (!pins_i.csn && cyc_q == 2 && pins_i.dq[2]) begin
            pins_o.rwds = 2'b11;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cyc_q       <= 0;
            widx_q      <= 0;
            lat2_q      <= 1'b0;
            rd_active_q <= 1'b0;
            rd_dq_q     <= '0;
            ca_q        <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= {8'(i) ^ 8'ha5, ~8'(i)};
            end
        end else if (pins_i.csn) begin
            cyc_q       <= 0;
            widx_q      <= 0;
            rd_active_q <= 1'b0;
        end else if (pins_i.ck_en) begin
            // Only clocked cycles move the access along
            cyc_q <= cyc_q + 1;
            if (cyc_q < 3) begin
                // CA arrives MSB word first
                ca_q <= hbus_ca_t'({ca_q[31:0], pins_i.dq});
                if (cyc_q == 2) begin
                    lat2_q <= pins_i.dq[2];
                end
            end else if (pins_i.dq_oe && pins_i.rwds_oe
                         && cyc_q == data_start + widx_q) begin
                // Write words count only at the chosen access latency
                if (!ca_q.rw && !ca_q.space) begin
                    // RWDS high masks the byte
                    if (!pins_i.rwds[0]) begin
                        mem[idx][7:0] <= pins_i.dq[7:0];
                    end
                    if (!pins_i.rwds[1]) begin
                        mem[idx][15:8] <= pins_i.dq[15:8];
                    end
                end
                widx_q <= widx_q + 1;
            end else if (ca_q.rw && !ca_q.space && cyc_q + 1 >= data_start
                         && widx_q < `HBUS_WORDS) begin
                rd_active_q <= 1'b1;
                rd_dq_q     <= mem[idx];
                widx_q      <= widx_q + 1;
            end else begin
                rd_active_q <= 1'b0;
            end
        end
    end

endmodule

// File: source/hbus_top.sv
`timescale 1ns/10ps

module hbus_top
    import axi_lite_pkg::*;
    import hbus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  axil_req_t axi_req_i,
    output axil_rsp_t axi_rsp_o,

    output hbus_out_t hbus_o,
    input  hbus_in_t  hbus_i
);

    logic        s_req_valid, s_req_ready;
    hbus_req_t   s_req;
    logic        c_req_valid, c_req_ready;
    hbus_req_t   c_req;
    logic        c_rsp_valid, c_rsp_ready;
    hbus_rsp_t   c_rsp;
    logic        s_rsp_valid, s_rsp_ready;
    hbus_rsp_t   s_rsp;
    logic        ca_load, ca_shift;
    logic [15:0] ca_word;

    hbus_axi_slave u_slave (
        .clk         (clk),
        .rst         (rst),
        .axi_req_i   (axi_req_i),
        .axi_rsp_o   (axi_rsp_o),
        .req_valid_o (s_req_valid),
        .req_ready_i (s_req_ready),
        .req_o       (s_req),
        .rsp_valid_i (s_rsp_valid),
        .rsp_ready_o (s_rsp_ready),
        .rsp_i       (s_rsp)
    );

    // Request path, slave to controller
    hbus_req_reg #(.payload_t(hbus_req_t)) u_req_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (s_req_valid),
        .in_ready_o  (s_req_ready),
        .in_data_i   (s_req),
        .out_valid_o (c_req_valid),
        .out_ready_i (c_req_ready),
        .out_data_o  (c_req)
    );

    // Response path, controller back to slave
    hbus_req_reg #(.payload_t(hbus_rsp_t)) u_rsp_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (c_rsp_valid),
        .in_ready_o  (c_rsp_ready),
        .in_data_i   (c_rsp),
        .out_valid_o (s_rsp_valid),
        .out_ready_i (s_rsp_ready),
        .out_data_o  (s_rsp)
    );

    hbus_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (c_req_valid),
        .req_ready_o (c_req_ready),
        .req_i       (c_req),
        .rsp_valid_o (c_rsp_valid),
        .rsp_ready_i (c_rsp_ready),
        .rsp_o       (c_rsp),
        .ca_load_o   (ca_load),
        .ca_shift_o  (ca_shift),
        .ca_word_i   (ca_word),
        .hbus_o      (hbus_o),
        .hbus_i      (hbus_i)
    );

    hbus_ca_shifter u_ca (
        .clk     (clk),
        .rst     (rst),
        .load_i  (ca_load),
        .shift_i (ca_shift),
        .req_i   (c_req),
        .word_o  (ca_word)
    );

endmodule

// File: source/hbus_ctrl.sv
`timescale 1ns/10ps
`include "hbus_macros.svh"

module hbus_ctrl
    import hbus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  hbus_req_t   req_i,

    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output hbus_rsp_t   rsp_o,

    output logic        ca_load_o,
    output logic        ca_shift_o,
    input  logic [15:0] ca_word_i,

    output hbus_out_t   hbus_o,
    input  hbus_in_t    hbus_i
);

    localparam int CNT_MAX = (2 * `TACC_COUNT > `TIMEOUT_COUNT) ?
                             2 * `TACC_COUNT : `TIMEOUT_COUNT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam int WIDX_W  = $clog2(`HBUS_WORDS);

    localparam logic [CNT_W-1:0] RESET_LOAD   = CNT_W'(`RESET_COUNT);
    localparam logic [CNT_W-1:0] CMD_LOAD     = CNT_W'(2);
    localparam logic [CNT_W-1:0] LAT1_LOAD    = CNT_W'(`TACC_COUNT - 1);
    localparam logic [CNT_W-1:0] LAT2_LOAD    = CNT_W'(2 * `TACC_COUNT - 1);
    localparam logic [CNT_W-1:0] TIMEOUT_LOAD = CNT_W'(`TIMEOUT_COUNT - 1);
    localparam logic [WIDX_W-1:0] LAST_WORD   = WIDX_W'(`HBUS_WORDS - 1);

    hbus_state_e       state_q;
    logic [CNT_W-1:0]  count_q;
    logic [WIDX_W-1:0] widx_q;
    logic              rsp_valid_q;
    logic              err_q;
    hbus_req_t         req_q;
    logic [31:0]       rdata_q;
    logic              req_hs;
    logic              strobe;
    logic              last_word;

    // New work only once the response slot is free
    assign req_ready_o = (state_q == ST_IDLE || state_q == ST_ERROR)
                         && !rsp_valid_q && rsp_ready_i;
    assign req_hs      = req_valid_i && req_ready_o;
    assign strobe      = hbus_i.rwds != 2'b00;
    assign last_word   = widx_q == LAST_WORD;

    assign ca_load_o  = req_hs && state_q == ST_IDLE;
    assign ca_shift_o = state_q == ST_COMMAND && count_q != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= ST_RESET;
            count_q     <= RESET_LOAD;
            widx_q      <= '0;
            rsp_valid_q <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            if (rsp_valid_q && rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            unique case (state_q)
                ST_RESET: begin
                    if (count_q == '0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                ST_IDLE: begin
                    if (req_hs) begin
                        state_q <= ST_COMMAND;
                        count_q <= CMD_LOAD;
                    end
                end
                ST_COMMAND: begin
                    if (count_q == '0) begin
                        // Memory asks for double latency with RWDS high
                        count_q <= (hbus_i.rwds == 2'b11) ? LAT2_LOAD : LAT1_LOAD;
                        state_q <= ST_LATENCY;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                ST_LATENCY: begin
                    if (count_q == '0) begin
                        widx_q <= '0;
                        if (req_q.rw) begin
                            state_q <= ST_READ;
                            count_q <= TIMEOUT_LOAD;
                        end else begin
                            state_q <= ST_WRITE;
                        end
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (last_word) begin
                        state_q     <= ST_IDLE;
                        rsp_valid_q <= 1'b1;
                        err_q       <= 1'b0;
                    end else begin
                        widx_q <= widx_q + 1'b1;
                    end
                end
                ST_READ: begin
                    if (strobe) begin
                        widx_q  <= widx_q + 1'b1;
                        count_q <= TIMEOUT_LOAD;
                        if (last_word) begin
                            state_q     <= ST_IDLE;
                            rsp_valid_q <= 1'b1;
                            err_q       <= 1'b0;
                        end
                    end else if (count_q == '0) begin
                        // No strobe in time, stuck here until reset
                        state_q     <= ST_ERROR;
                        rsp_valid_q <= 1'b1;
                        err_q       <= 1'b1;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                ST_ERROR: begin
                    if (req_hs) begin
                        rsp_valid_q <= 1'b1;
                        err_q       <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_ERROR;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_hs) begin
            req_q <= req_i;
        end
        if (state_q == ST_READ && strobe) begin
            rdata_q[16*widx_q +: 16] <= hbus_i.dq;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o.rdata = rdata_q;
    assign rsp_o.err   = err_q;

    // Pin decode from the current state
    always_comb begin
        hbus_o.rstn    = state_q != ST_RESET;
        hbus_o.ck_en   = state_q == ST_COMMAND || state_q == ST_LATENCY
                         || state_q == ST_READ || state_q == ST_WRITE;
        hbus_o.csn     = !hbus_o.ck_en;
        hbus_o.dq      = 16'h0000;
        hbus_o.dq_oe   = 1'b0;
        hbus_o.rwds    = 2'b00;
        hbus_o.rwds_oe = 1'b0;
        if (state_q == ST_COMMAND) begin
            hbus_o.dq    = ca_word_i;
            hbus_o.dq_oe = 1'b1;
        end else if (state_q == ST_WRITE) begin
            // Lower halfword goes first, RWDS high masks a byte
            hbus_o.dq      = req_q.wdata[16*widx_q +: 16];
            hbus_o.dq_oe   = 1'b1;
            hbus_o.rwds    = req_q.wmask[2*widx_q +: 2];
            hbus_o.rwds_oe = 1'b1;
        end
    end

endmodule

// File: source/hbus_ca_shifter.sv
`timescale 1ns/10ps

module hbus_ca_shifter
    import hbus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        load_i,
    input  logic        shift_i,
    input  hbus_req_t   req_i,

    output logic [15:0] word_o
);

    hbus_ca_t ca_next;
    hbus_ca_t ca_q;

    always_comb begin
        ca_next.rw       = req_i.rw;
        ca_next.space    = req_i.reg_space;
        // Linear bursts only
        ca_next.burst    = 1'b1;
        ca_next.addr_hi  = {1'b0, req_i.addr[30:3]};
        ca_next.reserved = '0;
        ca_next.addr_lo  = req_i.addr[2:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca_q <= '0;
        end else if (load_i) begin
            ca_q <= ca_next;
        end else if (shift_i) begin
            ca_q <= hbus_ca_t'({ca_q[31:0], 16'h0000});
        end
    end

    // Next 16 bits on the bus
    assign word_o = ca_q[47:32];

endmodule

// File: source/hbus_axi_slave.sv
`timescale 1ns/10ps

module hbus_axi_slave
    import axi_lite_pkg::*;
    import hbus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  axil_req_t axi_req_i,
    output axil_rsp_t axi_rsp_o,

    output logic      req_valid_o,
    input  logic      req_ready_i,
    output hbus_req_t req_o,

    input  logic      rsp_valid_i,
    output logic      rsp_ready_o,
    input  hbus_rsp_t rsp_i
);

    logic      arready_q, awready_q, wready_q;
    logic      aw_done_q, w_done_q;
    logic      busy_q, is_read_q, req_valid_q;
    logic      ar_hs, aw_hs, w_hs;
    logic      write_started, write_go;
    logic      ar_take, aw_take, w_take;
    hbus_req_t req_q;

    assign ar_hs = axi_req_i.arvalid && arready_q;
    assign aw_hs = axi_req_i.awvalid && awready_q;
    assign w_hs  = axi_req_i.wvalid && wready_q;

    assign write_started = aw_done_q || w_done_q || awready_q || wready_q;
    assign write_go      = (aw_done_q || aw_hs) && (w_done_q || w_hs);

    // Read wins unless a write is already under way
    assign ar_take = !busy_q && !arready_q && axi_req_i.arvalid && !write_started;
    assign aw_take = !busy_q && !awready_q && !aw_done_q && axi_req_i.awvalid
                     && !arready_q && (write_started || !axi_req_i.arvalid);
    assign w_take  = !busy_q && !wready_q && !w_done_q && axi_req_i.wvalid
                     && !arready_q && (write_started || !axi_req_i.arvalid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready_q   <= 1'b0;
            awready_q   <= 1'b0;
            wready_q    <= 1'b0;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
            busy_q      <= 1'b0;
            is_read_q   <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            arready_q <= ar_take;
            awready_q <= aw_take;
            wready_q  <= w_take;
            if (req_valid_q && req_ready_i) begin
                req_valid_q <= 1'b0;
            end
            if (ar_hs) begin
                busy_q      <= 1'b1;
                is_read_q   <= 1'b1;
                req_valid_q <= 1'b1;
            end else if (write_go) begin
                busy_q      <= 1'b1;
                is_read_q   <= 1'b0;
                req_valid_q <= 1'b1;
                aw_done_q   <= 1'b0;
                w_done_q    <= 1'b0;
            end else begin
                // AW and W may arrive in either order
                if (aw_hs) aw_done_q <= 1'b1;
                if (w_hs) w_done_q <= 1'b1;
            end
            if (rsp_valid_i && rsp_ready_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Bit 31 picks register space, bits 30:1 the halfword
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            req_q.rw        <= 1'b1;
            req_q.reg_space <= axi_req_i.araddr[31];
            req_q.addr      <= {1'b0, axi_req_i.araddr[30:1]};
        end
        if (aw_hs) begin
            req_q.rw        <= 1'b0;
            req_q.reg_space <= axi_req_i.awaddr[31];
            req_q.addr      <= {1'b0, axi_req_i.awaddr[30:1]};
        end
        if (w_hs) begin
            req_q.wdata <= axi_req_i.wdata;
            req_q.wmask <= ~axi_req_i.wstrb;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

    // Response stays in the holding register until B or R is taken
    assign rsp_ready_o = is_read_q ? axi_req_i.rready : axi_req_i.bready;

    assign axi_rsp_o.arready = arready_q;
    assign axi_rsp_o.awready = awready_q;
    assign axi_rsp_o.wready  = wready_q;
    assign axi_rsp_o.bvalid  = rsp_valid_i && !is_read_q;
    assign axi_rsp_o.bresp   = rsp_i.err ? SLVERR : OKAY;
    assign axi_rsp_o.rvalid  = rsp_valid_i && is_read_q;
    assign axi_rsp_o.rdata   = rsp_i.rdata;
    assign axi_rsp_o.rresp   = rsp_i.err ? SLVERR : OKAY;

endmodule

// File: source/hbus_req_reg.sv
`timescale 1ns/10ps

module hbus_req_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // Free when empty or when the held item leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

// File: source/hbus_pkg.sv
package hbus_pkg;

    // One memory access as seen by the controller
    typedef struct packed {
        logic        rw;
        logic        reg_space;
        logic [30:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
    } hbus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } hbus_rsp_t;

    // Command/address word, sent MSB first over three cycles
    typedef struct packed {
        logic        rw;
        logic        space;
        logic        burst;
        logic [28:0] addr_hi;
        logic [12:0] reserved;
        logic [2:0]  addr_lo;
    } hbus_ca_t;

    // Double-width pin word per clk cycle, bit 1 of rwds is the first edge
    typedef struct packed {
        logic        ck_en;
        logic        csn;
        logic        rstn;
        logic [15:0] dq;
        logic        dq_oe;
        logic [1:0]  rwds;
        logic        rwds_oe;
    } hbus_out_t;

    typedef struct packed {
        logic [15:0] dq;
        logic [1:0]  rwds;
    } hbus_in_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_COMMAND,
        ST_LATENCY,
        ST_READ,
        ST_WRITE,
        ST_ERROR
    } hbus_state_e;

endpackage

// File: source/axi_lite_pkg.sv
package axi_lite_pkg;

    // Only the codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Master to slave
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_e  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_e  rresp;
    } axil_rsp_t;

endpackage

// File: source/hbus_macros.svh
`ifndef HBUS_MACROS_SVH
`define HBUS_MACROS_SVH

// Initial access latency in clk cycles (35 ns at 200 MHz)
`define TACC_COUNT 7

// Cycles the memory reset is held low after rst
`define RESET_COUNT 2

// Read cycles allowed without an RWDS strobe
`define TIMEOUT_COUNT 15

// 16-bit words moved per access, one 32-bit AXI beat
`define HBUS_WORDS 2

`endif
